// File: rtl/mem_access_pkg.sv
`default_nettype none

package mem_access_pkg;
	typedef logic [19:0] page_t;
	typedef logic [13:0] table_index_t; // Low page bits
	typedef logic [5:0] tag_t;          // High page bits
	typedef logic [13:0] frame_t;
	typedef logic [8:0] node_t;
	typedef logic [11:0] var_t;
	typedef logic [25:0] mem_addr_t;
	typedef logic [15:0] mem_word_t;
	typedef logic [1:0] channel_t;
	typedef logic [95:0] result_t;      // Word k in bits 16k+15..16k
	typedef logic [3:0] burst_t;
	typedef logic [31:0] cfg_data_t;

	typedef enum logic [1:0] {
		fetch_node,
		fetch_simple_node,
		get_var,
		write_node_next
	} req_type_t;

	// Host register map
	localparam logic [1:0] cfg_select_page = 2'd0;
	localparam logic [1:0] cfg_entry_info = 2'd1;

	// Burst shapes of the node accesses
	localparam burst_t node_words = 4'd6;
	localparam burst_t simple_words = 4'd4;
	localparam mem_addr_t simple_offset = 26'd2;
	localparam burst_t write_words = 4'd2;

	// Entry-info word layout
	localparam int entry_var_valid_bit = 0;
	localparam int entry_frame_valid_bit = 1;
	localparam int entry_var_lsb = 4;
	localparam int entry_frame_lsb = 16;
endpackage

`default_nettype wire

// File: rtl/page_table.sv
`timescale 1ns/1ps
`default_nettype none

module page_table (
	input logic clk,
	input logic reset,
	input logic host_req,
	input logic host_we,
	input mem_access_pkg::table_index_t host_index,
	input mem_access_pkg::cfg_data_t host_entry,
	input mem_access_pkg::tag_t host_tag,
	input logic look_req,
	input mem_access_pkg::table_index_t look_index,
	output logic host_rvalid,
	output logic look_grant,
	output logic look_rvalid,
	output mem_access_pkg::tag_t rd_tag,
	output mem_access_pkg::cfg_data_t rd_entry
);
	localparam int entries = 2 ** $bits(mem_access_pkg::table_index_t);
	localparam int frame_bits = $bits(mem_access_pkg::frame_t);
	localparam int var_bits = $bits(mem_access_pkg::var_t);

	mem_access_pkg::tag_t tag_mem [entries];
	mem_access_pkg::frame_t frame_mem [entries];
	mem_access_pkg::var_t var_mem [entries];
	logic [entries-1:0] var_valid_q;   // Every page starts as a miss
	logic [entries-1:0] frame_valid_q;
	mem_access_pkg::table_index_t index;
	mem_access_pkg::cfg_data_t entry_word;
	logic host_write;

	assign look_grant = look_req && !host_req; // Host always wins
	assign index = host_req ? host_index : look_index;
	assign host_write = host_req && host_we;

	// Stored fields back into entry-info layout
	always_comb
	begin
		entry_word = '0;
		entry_word[mem_access_pkg::entry_var_valid_bit] = var_valid_q[index];
		entry_word[mem_access_pkg::entry_frame_valid_bit] = frame_valid_q[index];
		entry_word[mem_access_pkg::entry_var_lsb +: var_bits] = var_mem[index];
		entry_word[mem_access_pkg::entry_frame_lsb +: frame_bits] = frame_mem[index];
	end

	always_ff @(posedge clk)
	begin
		if (host_write)
		begin
			tag_mem[index] <= host_tag;
			frame_mem[index] <= host_entry[mem_access_pkg::entry_frame_lsb +: frame_bits];
			var_mem[index] <= host_entry[mem_access_pkg::entry_var_lsb +: var_bits];
		end
		rd_tag <= tag_mem[index];
		rd_entry <= entry_word;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			var_valid_q <= '0;
			frame_valid_q <= '0;
			host_rvalid <= 1'b0;
			look_rvalid <= 1'b0;
		end
		else
		begin
			if (host_write)
			begin
				var_valid_q[index] <= host_entry[mem_access_pkg::entry_var_valid_bit];
				frame_valid_q[index] <= host_entry[mem_access_pkg::entry_frame_valid_bit];
			end
			host_rvalid <= host_req && !host_we; // Data is tagged for its requester
			look_rvalid <= look_grant;
		end
	end
endmodule

`default_nettype wire

// File: rtl/host_config.sv
`timescale 1ns/1ps
`default_nettype none

module host_config (
	input logic clk,
	input logic reset,
	input logic [1:0] cfg_address,
	input logic cfg_write,
	input logic cfg_read,
	input mem_access_pkg::cfg_data_t cfg_writedata,
	input logic host_rvalid,
	input mem_access_pkg::cfg_data_t rd_entry,
	input logic miss_capture,
	input mem_access_pkg::page_t miss_page,
	input logic miss_is_var,
	output mem_access_pkg::cfg_data_t cfg_readdata,
	output logic cfg_readdatavalid,
	output logic host_req,
	output logic host_we,
	output mem_access_pkg::table_index_t host_index,
	output mem_access_pkg::tag_t host_tag,
	output mem_access_pkg::cfg_data_t host_entry,
	output logic entry_written
);
	logic entry_write;
	logic select_write;
	logic miss_read_q;
	mem_access_pkg::cfg_data_t miss_info_q;

	assign select_write = cfg_write && cfg_address == mem_access_pkg::cfg_select_page;
	assign entry_write = cfg_write && cfg_address == mem_access_pkg::cfg_entry_info;

	// Table access for an entry write or a selected-entry read
	assign host_req = entry_write || (cfg_read && cfg_address == mem_access_pkg::cfg_select_page);
	assign host_we = cfg_write;
	assign host_entry = cfg_writedata;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			host_index <= '0;
			host_tag <= '0;
			entry_written <= 1'b0;
			miss_read_q <= 1'b0;
		end
		else
		begin
			if (select_write)
				{host_tag, host_index} <= cfg_writedata[19:0];
			entry_written <= entry_write; // Table already holds the entry
			miss_read_q <= cfg_read && cfg_address == mem_access_pkg::cfg_entry_info;
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss_capture)
			miss_info_q <= {11'b0, miss_page, miss_is_var};
	end

	// Miss info answers in one cycle, a table read when its data is back
	assign cfg_readdatavalid = host_rvalid || miss_read_q;
	assign cfg_readdata = host_rvalid ? rd_entry : miss_info_q;
endmodule

`default_nettype wire

// File: rtl/page_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module page_lookup (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mem_access_pkg::req_type_t req_type,
	input mem_access_pkg::page_t req_page,
	input mem_access_pkg::node_t req_node,
	input mem_access_pkg::channel_t req_channel,
	input logic [31:0] req_data,
	input logic look_grant,
	input logic look_rvalid,
	input mem_access_pkg::tag_t rd_tag,
	input mem_access_pkg::cfg_data_t rd_entry,
	input logic entry_written,
	input logic issue_ready,
	output logic req_ready,
	output logic look_req,
	output mem_access_pkg::table_index_t look_index,
	output logic irq,
	output logic miss_capture,
	output mem_access_pkg::page_t miss_page,
	output logic miss_is_var,
	output logic issue_valid,
	output mem_access_pkg::req_type_t issue_type,
	output mem_access_pkg::mem_addr_t issue_addr,
	output mem_access_pkg::channel_t issue_channel,
	output mem_access_pkg::var_t issue_var,
	output logic [31:0] issue_data
);
	typedef enum logic [2:0] {
		st_idle,
		st_lookup, // Waiting for the table grant
		st_wait,   // Entry comes back
		st_miss,   // Host is filling the entry
		st_issue
	} state_t;

	state_t state_q;
	mem_access_pkg::page_t page_q;
	mem_access_pkg::node_t node_q;
	logic is_var;
	logic hit;
	mem_access_pkg::mem_addr_t base_addr;

	assign req_ready = state_q == st_idle;
	assign look_req = state_q == st_lookup;
	assign look_index = page_q[13:0];
	assign irq = state_q == st_miss;
	assign issue_valid = state_q == st_issue;

	assign is_var = issue_type == mem_access_pkg::get_var;
	assign hit = rd_tag == page_q[19:14]
		&& (is_var ? rd_entry[mem_access_pkg::entry_var_valid_bit]
			: rd_entry[mem_access_pkg::entry_frame_valid_bit]);
	assign base_addr = {rd_entry[mem_access_pkg::entry_frame_lsb +: 14], node_q, 3'b000};

	assign miss_capture = state_q == st_wait && look_rvalid && !hit;
	assign miss_page = page_q;
	assign miss_is_var = is_var;

	always_ff @(posedge clk)
	begin
		if (req_valid && req_ready)
		begin
			issue_type <= req_type;
			page_q <= req_page;
			node_q <= req_node;
			issue_channel <= req_channel;
			issue_data <= req_data;
		end
		if (state_q == st_wait && look_rvalid)
		begin
			issue_addr <= (issue_type == mem_access_pkg::fetch_simple_node)
				? base_addr + mem_access_pkg::simple_offset : base_addr;
			issue_var <= rd_entry[mem_access_pkg::entry_var_lsb +: 12];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state_q <= st_idle;
		else
		begin
			case (state_q)
				st_idle:
					if (req_valid)
						state_q <= st_lookup;
				st_lookup:
					if (look_grant)
						state_q <= st_wait;
				st_wait:
					if (look_rvalid)
						state_q <= hit ? st_issue : st_miss;
				st_miss:
					if (entry_written)
						state_q <= st_lookup; // Retry with the new entry
				st_issue:
					if (issue_ready)
						state_q <= st_idle;
				default:
					state_q <= st_idle;
			endcase
		end
	end
endmodule

`default_nettype wire

// File: rtl/memory_issue.sv
`timescale 1ns/1ps
`default_nettype none

module memory_issue (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input mem_access_pkg::req_type_t issue_type,
	input mem_access_pkg::mem_addr_t issue_addr,
	input mem_access_pkg::channel_t issue_channel,
	input mem_access_pkg::var_t issue_var,
	input logic [31:0] issue_data,
	input logic mem_waitrequest,
	input logic pend_ready,
	output logic issue_ready,
	output mem_access_pkg::mem_addr_t mem_address,
	output logic mem_read,
	output logic mem_write,
	output mem_access_pkg::burst_t mem_burstcount,
	output mem_access_pkg::mem_word_t mem_writedata,
	output logic pend_valid,
	output mem_access_pkg::channel_t pend_channel,
	output mem_access_pkg::burst_t pend_words,
	output logic pend_is_var,
	output mem_access_pkg::var_t pend_var
);
	logic is_var;
	logic is_write;
	logic write_last;
	mem_access_pkg::burst_t word_q; // Write word being offered

	assign is_var = issue_type == mem_access_pkg::get_var;
	assign is_write = issue_type == mem_access_pkg::write_node_next;
	assign write_last = word_q == mem_access_pkg::write_words - 1'b1;

	assign mem_address = issue_addr;
	assign mem_read = issue_valid && !is_var && !is_write && pend_ready; // FIFO slot is free
	assign mem_write = issue_valid && is_write;
	assign mem_writedata = issue_data[word_q[0]*16 +: 16];

	always_comb
	begin
		if (is_write)
			mem_burstcount = mem_access_pkg::write_words;
		else if (issue_type == mem_access_pkg::fetch_simple_node)
			mem_burstcount = mem_access_pkg::simple_words;
		else
			mem_burstcount = mem_access_pkg::node_words;
	end

	// Pending entry for every accepted read command and every get variable
	assign pend_valid = issue_valid && (is_var || (mem_read && !mem_waitrequest));
	assign pend_channel = issue_channel;
	assign pend_words = mem_burstcount;
	assign pend_is_var = is_var;
	assign pend_var = issue_var;

	always_comb
	begin
		if (is_var)
			issue_ready = pend_ready;
		else if (is_write)
			issue_ready = !mem_waitrequest && write_last;
		else
			issue_ready = pend_ready && !mem_waitrequest;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			word_q <= '0;
		else if (mem_write && !mem_waitrequest)
			word_q <= write_last ? '0 : word_q + 1'b1;
	end
endmodule

`default_nettype wire

// File: rtl/response_collect.sv
`timescale 1ns/1ps
`default_nettype none

module response_collect #(
	parameter int pending_depth_bits = 3
) (
	input logic clk,
	input logic reset,
	input logic pend_valid,
	input mem_access_pkg::channel_t pend_channel,
	input mem_access_pkg::burst_t pend_words,
	input logic pend_is_var,
	input mem_access_pkg::var_t pend_var,
	input mem_access_pkg::mem_word_t mem_readdata,
	input logic mem_readdatavalid,
	input logic result_ready,
	output logic pend_ready,
	output logic result_valid,
	output mem_access_pkg::result_t result_data,
	output mem_access_pkg::channel_t result_channel
);
	localparam int depth = 2 ** pending_depth_bits;

	mem_access_pkg::channel_t fifo_channel [depth];
	mem_access_pkg::burst_t fifo_words [depth];
	logic fifo_is_var [depth];
	mem_access_pkg::var_t fifo_var [depth];
	logic [pending_depth_bits:0] wr_ptr_q;
	logic [pending_depth_bits:0] rd_ptr_q;
	logic [pending_depth_bits-1:0] wr_index;
	logic [pending_depth_bits-1:0] rd_index;
	logic empty;
	logic push;
	logic head_is_var;
	mem_access_pkg::burst_t count_q;
	mem_access_pkg::mem_word_t skid_q;
	mem_access_pkg::mem_word_t word;
	logic skid_valid_q;
	logic word_valid;
	logic word_last;
	logic word_take;
	mem_access_pkg::result_t data_q;
	mem_access_pkg::result_t assembled;

	assign wr_index = wr_ptr_q[pending_depth_bits-1:0];
	assign rd_index = rd_ptr_q[pending_depth_bits-1:0];
	assign empty = wr_ptr_q == rd_ptr_q;
	assign pend_ready = !(wr_index == rd_index
		&& wr_ptr_q[pending_depth_bits] != rd_ptr_q[pending_depth_bits]);
	assign push = pend_valid && pend_ready;

	assign head_is_var = fifo_is_var[rd_index];
	assign result_channel = fifo_channel[rd_index];

	// Skid word goes first, it is older than the bus word
	assign word_valid = skid_valid_q || mem_readdatavalid;
	assign word = skid_valid_q ? skid_q : mem_readdata;
	assign word_last = count_q == fifo_words[rd_index] - 1'b1;
	assign word_take = word_valid && !empty && !head_is_var && (!word_last || result_ready);

	always_comb
	begin
		assembled = data_q;
		assembled[count_q*16 +: 16] = word;
	end

	assign result_valid = !empty && (head_is_var || (word_valid && word_last));
	assign result_data = head_is_var ? mem_access_pkg::result_t'(fifo_var[rd_index]) : assembled;

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			fifo_channel[wr_index] <= pend_channel;
			fifo_words[wr_index] <= pend_words;
			fifo_is_var[wr_index] <= pend_is_var;
			fifo_var[wr_index] <= pend_var;
		end
		if (mem_readdatavalid && (skid_valid_q || !word_take))
			skid_q <= mem_readdata;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			skid_valid_q <= 1'b0;
			data_q <= '0; // Unused upper words read as zero
		end
		else
		begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (result_valid && result_ready)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			skid_valid_q <= skid_valid_q ? (!word_take || mem_readdatavalid)
				: (mem_readdatavalid && !word_take);
			if (word_take && word_last)
			begin
				count_q <= '0;
				data_q <= '0;
			end
			else if (word_take)
			begin
				count_q <= count_q + 1'b1;
				data_q <= assembled;
			end
		end
	end
endmodule

`default_nettype wire

// File: rtl/mem_access_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_top #(
	parameter int pending_depth_bits = 3
) (
	input logic clk,
	input logic reset,
	// Requests from the controller
	input logic req_valid,
	output logic req_ready,
	input mem_access_pkg::req_type_t req_type,
	input mem_access_pkg::page_t req_page,
	input mem_access_pkg::node_t req_node,
	input mem_access_pkg::channel_t req_channel,
	input logic [31:0] req_data,
	// Results back to the controller
	output logic result_valid,
	input logic result_ready,
	output mem_access_pkg::result_t result_data,
	output mem_access_pkg::channel_t result_channel,
	// Host configuration port
	input logic [1:0] cfg_address,
	input logic cfg_write,
	input logic cfg_read,
	input mem_access_pkg::cfg_data_t cfg_writedata,
	output mem_access_pkg::cfg_data_t cfg_readdata,
	output logic cfg_readdatavalid,
	output logic irq,
	// Node memory bus
	output mem_access_pkg::mem_addr_t mem_address,
	output logic mem_read,
	output logic mem_write,
	output mem_access_pkg::burst_t mem_burstcount,
	output mem_access_pkg::mem_word_t mem_writedata,
	input logic mem_waitrequest,
	input mem_access_pkg::mem_word_t mem_readdata,
	input logic mem_readdatavalid
);
	logic host_req;
	logic host_we;
	logic host_rvalid;
	mem_access_pkg::table_index_t host_index;
	mem_access_pkg::tag_t host_tag;
	mem_access_pkg::cfg_data_t host_entry;
	logic look_req;
	logic look_grant;
	logic look_rvalid;
	mem_access_pkg::table_index_t look_index;
	mem_access_pkg::tag_t rd_tag;
	mem_access_pkg::cfg_data_t rd_entry;
	logic entry_written;
	logic miss_capture;
	mem_access_pkg::page_t miss_page;
	logic miss_is_var;
	logic issue_valid;
	logic issue_ready;
	mem_access_pkg::req_type_t issue_type;
	mem_access_pkg::mem_addr_t issue_addr;
	mem_access_pkg::channel_t issue_channel;
	mem_access_pkg::var_t issue_var;
	logic [31:0] issue_data;
	logic pend_valid;
	logic pend_ready;
	mem_access_pkg::channel_t pend_channel;
	mem_access_pkg::burst_t pend_words;
	logic pend_is_var;
	mem_access_pkg::var_t pend_var;

	page_table u_page_table (
		.clk, .reset,
		.host_req, .host_we, .host_index, .host_entry, .host_tag,
		.look_req, .look_index,
		.host_rvalid, .look_grant, .look_rvalid, .rd_tag, .rd_entry
	);

	host_config u_host_config (
		.clk, .reset,
		.cfg_address, .cfg_write, .cfg_read, .cfg_writedata,
		.host_rvalid, .rd_entry, .miss_capture, .miss_page, .miss_is_var,
		.cfg_readdata, .cfg_readdatavalid,
		.host_req, .host_we, .host_index, .host_tag, .host_entry, .entry_written
	);

	page_lookup u_page_lookup (
		.clk, .reset,
		.req_valid, .req_type, .req_page, .req_node, .req_channel, .req_data,
		.look_grant, .look_rvalid, .rd_tag, .rd_entry, .entry_written, .issue_ready,
		.req_ready, .look_req, .look_index, .irq,
		.miss_capture, .miss_page, .miss_is_var,
		.issue_valid, .issue_type, .issue_addr, .issue_channel, .issue_var, .issue_data
	);

	memory_issue u_memory_issue (
		.clk, .reset,
		.issue_valid, .issue_type, .issue_addr, .issue_channel, .issue_var, .issue_data,
		.mem_waitrequest, .pend_ready, .issue_ready,
		.mem_address, .mem_read, .mem_write, .mem_burstcount, .mem_writedata,
		.pend_valid, .pend_channel, .pend_words, .pend_is_var, .pend_var
	);

	response_collect #(
		.pending_depth_bits(pending_depth_bits)
	) u_response_collect (
		.clk, .reset,
		.pend_valid, .pend_channel, .pend_words, .pend_is_var, .pend_var,
		.mem_readdata, .mem_readdatavalid, .result_ready,
		.pend_ready, .result_valid, .result_data, .result_channel
	);
endmodule

`default_nettype wire

// File: verification/node_memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module node_memory_model (
	input logic clk,
	input logic reset,
	input mem_access_pkg::mem_addr_t mem_address,
	input logic mem_read,
	input logic mem_write,
	input mem_access_pkg::burst_t mem_burstcount,
	input mem_access_pkg::mem_word_t mem_writedata,
	input logic return_enable, // Words only go out while the result side can move
	output logic mem_waitrequest,
	output mem_access_pkg::mem_word_t mem_readdata,
	output logic mem_readdatavalid
);
	mem_access_pkg::mem_addr_t written_addr [$];
	mem_access_pkg::mem_word_t written_data [$];
	mem_access_pkg::mem_word_t read_data [$]; // Captured at command time
	mem_access_pkg::burst_t write_beat;
	logic [15:0] lfsr;
	logic [1:0] delay;
	logic wait_bit;
	logic word_ready_q;

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return state[0] ? (state >> 1) ^ 16'hB400 : state >> 1;
	endfunction

	// Latest write wins, anything else reads as the address pattern
	function automatic mem_access_pkg::mem_word_t stored_word(input mem_access_pkg::mem_addr_t addr);
		mem_access_pkg::mem_word_t value;
		value = addr[15:0] ^ 16'h5A5A;
		foreach (written_addr[i])
			if (written_addr[i] == addr)
				value = written_data[i];
		return value;
	endfunction

	assign mem_readdatavalid = word_ready_q && return_enable;

	initial
	begin
		mem_waitrequest = 1'b0;
		mem_readdata = '0;
		word_ready_q = 1'b0;
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			lfsr = 16'd68;
			delay = '0;
			write_beat = '0;
			read_data.delete();
			mem_waitrequest <= 1'b0;
			word_ready_q <= 1'b0;
		end
		else
		begin
			if (mem_write && !mem_waitrequest)
			begin
				written_addr.push_back(mem_address + write_beat); // Beats follow the base
				written_data.push_back(mem_writedata);
				write_beat = (write_beat == mem_burstcount - 1'b1) ? '0 : write_beat + 1'b1;
			end
			if (mem_read && !mem_waitrequest)
				for (int k = 0; k < mem_burstcount; k++)
					read_data.push_back(stored_word(mem_address + k));
			if (mem_readdatavalid)
			begin
				void'(read_data.pop_front());
				lfsr = lfsr_next(lfsr);
				delay[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				delay[1] = lfsr[0]; // Gap of 0 to 3 cycles to the next word
			end
			else if (delay != 0)
				delay = delay - 1'b1;
			lfsr = lfsr_next(lfsr);
			wait_bit = lfsr[0];
			lfsr = lfsr_next(lfsr);
			mem_waitrequest <= wait_bit && lfsr[0];
			word_ready_q <= read_data.size() != 0 && delay == 0;
			mem_readdata <= (read_data.size() != 0) ? read_data[0] : '0;
		end
	end
endmodule

`default_nettype wire

// File: verification/tb_mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_access;
	localparam int row_count = 24;
	localparam int timeout_cycles = row_count * 200 + 100;
	localparam int clear_var_row = 10; // Entry loses its variable before this row

	logic clk;
	logic reset;
	logic req_valid;
	logic req_ready;
	mem_access_pkg::req_type_t req_type;
	mem_access_pkg::page_t req_page;
	mem_access_pkg::node_t req_node;
	mem_access_pkg::channel_t req_channel;
	logic [31:0] req_data;
	logic result_valid;
	logic result_ready;
	mem_access_pkg::result_t result_data;
	mem_access_pkg::channel_t result_channel;
	logic [1:0] cfg_address;
	logic cfg_write;
	logic cfg_read;
	mem_access_pkg::cfg_data_t cfg_writedata;
	mem_access_pkg::cfg_data_t cfg_readdata;
	logic cfg_readdatavalid;
	logic irq;
	mem_access_pkg::mem_addr_t mem_address;
	logic mem_read;
	logic mem_write;
	mem_access_pkg::burst_t mem_burstcount;
	mem_access_pkg::mem_word_t mem_writedata;
	logic mem_waitrequest;
	mem_access_pkg::mem_word_t mem_readdata;
	logic mem_readdatavalid;

	// Stimulus table
	mem_access_pkg::req_type_t row_type [$];
	mem_access_pkg::page_t row_page [$];
	mem_access_pkg::node_t row_node [$];
	mem_access_pkg::channel_t row_channel [$];
	logic [31:0] row_data [$];
	logic row_miss [$];

	mem_access_pkg::result_t expected_data [$];
	mem_access_pkg::channel_t expected_channel [$];
	mem_access_pkg::mem_addr_t ref_addr [$];
	mem_access_pkg::mem_word_t ref_data [$];
	mem_access_pkg::mem_addr_t bus_write_addr [$];
	mem_access_pkg::mem_word_t bus_write_data [$];
	mem_access_pkg::mem_addr_t last_read_addr;
	mem_access_pkg::burst_t last_read_burst;
	mem_access_pkg::page_t cur_page;
	mem_access_pkg::cfg_data_t last_entry;
	logic cur_is_var;
	logic [15:0] lfsr;
	int read_count = 0;
	int error_count = 0;
	int cycle_count = 0;

	mem_access_top #(
		.pending_depth_bits(3)
	) DUT (.*);

	node_memory_model memory (
		.clk, .reset,
		.mem_address, .mem_read, .mem_write, .mem_burstcount, .mem_writedata,
		.return_enable(result_ready),
		.mem_waitrequest, .mem_readdata, .mem_readdatavalid
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return state[0] ? (state >> 1) ^ 16'hB400 : state >> 1;
	endfunction

	task automatic check_value(input logic [95:0] got, input logic [95:0] expected,
		input string what);
		if (got !== expected)
		begin
			error_count++;
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("Done: errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic add_row(input mem_access_pkg::req_type_t kind, input logic [19:0] page,
		input logic [8:0] node, input logic [1:0] channel, input logic [31:0] data,
		input logic miss);
		row_type.push_back(kind);
		row_page.push_back(page);
		row_node.push_back(node);
		row_channel.push_back(channel);
		row_data.push_back(data);
		row_miss.push_back(miss);
	endtask

	// Host fill rule: frame from the low page bits, both valid bits set
	function automatic mem_access_pkg::cfg_data_t entry_for(input mem_access_pkg::page_t page);
		return {2'b00, page[13:0] ^ 14'h1555, page[11:0], 4'b0011};
	endfunction

	function automatic mem_access_pkg::mem_addr_t node_base(input mem_access_pkg::page_t page,
		input mem_access_pkg::node_t node);
		return {page[13:0] ^ 14'h1555, node, 3'b000};
	endfunction

	function automatic mem_access_pkg::mem_word_t ref_word(input mem_access_pkg::mem_addr_t addr);
		mem_access_pkg::mem_word_t value;
		value = addr[15:0] ^ 16'h5A5A;
		foreach (ref_addr[i])
			if (ref_addr[i] == addr)
				value = ref_data[i];
		return value;
	endfunction

	function automatic mem_access_pkg::result_t expected_result(
		input mem_access_pkg::req_type_t kind, input mem_access_pkg::page_t page,
		input mem_access_pkg::node_t node);
		mem_access_pkg::mem_addr_t base;
		mem_access_pkg::result_t r;
		base = node_base(page, node);
		r = '0;
		if (kind == mem_access_pkg::fetch_node)
			for (int k = 0; k < 6; k++)
				r[k*16 +: 16] = ref_word(base + k);
		else if (kind == mem_access_pkg::fetch_simple_node)
			for (int k = 0; k < 4; k++)
				r[k*16 +: 16] = ref_word(base + 2 + k); // Starts at word 2
		else
			r[11:0] = page[11:0];
		return r;
	endfunction

	task automatic cfg_write_word(input logic [1:0] addr, input mem_access_pkg::cfg_data_t data);
		@(posedge clk);
		#1;
		cfg_address = addr;
		cfg_writedata = data;
		cfg_write = 1'b1;
		@(posedge clk);
		#1;
		cfg_write = 1'b0;
	endtask

	task automatic cfg_read_word(input logic [1:0] addr, output mem_access_pkg::cfg_data_t data);
		@(posedge clk);
		#1;
		cfg_address = addr;
		cfg_read = 1'b1;
		@(posedge clk);
		#1;
		cfg_read = 1'b0;
		@(negedge clk);
		while (!cfg_readdatavalid)
			@(negedge clk);
		data = cfg_readdata;
	endtask

	task automatic write_entry(input mem_access_pkg::page_t page,
		input mem_access_pkg::cfg_data_t entry);
		cfg_write_word(mem_access_pkg::cfg_select_page, {12'b0, page});
		cfg_write_word(mem_access_pkg::cfg_entry_info, entry);
		last_entry = entry;
	endtask

	// Memory traffic that one finished request must have left on the bus
	task automatic check_bus(input int i, input int reads_before);
		mem_access_pkg::mem_addr_t base;
		logic [31:0] data;
		logic simple;
		base = node_base(row_page[i], row_node[i]);
		data = row_data[i];
		simple = row_type[i] == mem_access_pkg::fetch_simple_node;
		if (row_type[i] == mem_access_pkg::write_node_next)
		begin
			check_value(bus_write_addr.size(), 2, "write beat count");
			for (int k = 0; k < 2; k++)
			begin
				check_value(bus_write_addr.pop_front(), base, "write address");
				check_value(bus_write_data.pop_front(), data[k*16 +: 16], "write word");
			end
		end
		else if (row_type[i] == mem_access_pkg::get_var)
			check_value(read_count, reads_before, "read count for get variable");
		else
		begin
			check_value(read_count, reads_before + 1, "read command count");
			check_value(last_read_addr, simple ? base + 2 : base, "read address");
			check_value(last_read_burst, simple ? 4 : 6, "read burst length");
		end
	endtask

	// Host side of the miss interrupt
	initial
	begin : host_service
		mem_access_pkg::cfg_data_t info;
		forever
		begin
			@(negedge clk);
			if (irq)
			begin
				cfg_read_word(mem_access_pkg::cfg_entry_info, info);
				check_value(info, {11'b0, cur_page, cur_is_var}, "miss info");
				write_entry(info[20:1], entry_for(info[20:1]));
				while (irq)
					@(negedge clk);
			end
		end
	end

	// Random stalls on the result port
	initial
	begin : ready_stalls
		logic stall;
		lfsr = 16'd68;
		@(negedge reset);
		forever
		begin
			@(posedge clk);
			#1;
			lfsr = lfsr_next(lfsr);
			stall = lfsr[0];
			lfsr = lfsr_next(lfsr);
			result_ready = !(stall && lfsr[0]);
		end
	end

	// Mid-cycle sampling, a transfer seen here happens at the next rising edge
	always @(negedge clk)
	begin
		if (mem_read && !mem_waitrequest)
		begin
			read_count++;
			last_read_addr = mem_address;
			last_read_burst = mem_burstcount;
		end
		if (mem_write && !mem_waitrequest)
		begin
			check_value(mem_burstcount, 2, "write burst length");
			bus_write_addr.push_back(mem_address);
			bus_write_data.push_back(mem_writedata);
		end
		if (result_valid && result_ready)
		begin
			check_value(expected_data.size() != 0, 1'b1, "result with none outstanding");
			check_value(result_channel, expected_channel.pop_front(), "result channel");
			check_value(result_data, expected_data.pop_front(), "result data");
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > timeout_cycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Done: errors found");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin : main_sequence
		mem_access_pkg::cfg_data_t entry;
		mem_access_pkg::mem_addr_t base;
		logic irq_seen;
		int reads_before;
		reset = 1'b1;
		req_valid = 1'b0;
		req_type = mem_access_pkg::fetch_node;
		req_page = '0;
		req_node = '0;
		req_channel = '0;
		req_data = '0;
		result_ready = 1'b1;
		cfg_address = '0;
		cfg_write = 1'b0;
		cfg_read = 1'b0;
		cfg_writedata = '0;
		//      type                                 page       node    ch  write data    miss
		add_row(mem_access_pkg::fetch_node,        20'h12345, 9'h011, 2'd0, 32'h0,         1'b1);
		add_row(mem_access_pkg::fetch_node,        20'h12345, 9'h022, 2'd1, 32'h0,         1'b0);
		add_row(mem_access_pkg::get_var,           20'h12345, 9'h000, 2'd2, 32'h0,         1'b0);
		add_row(mem_access_pkg::fetch_simple_node, 20'h0ABCD, 9'h1F0, 2'd3, 32'h0,         1'b1);
		add_row(mem_access_pkg::write_node_next,   20'h12345, 9'h011, 2'd0, 32'hBEEF_1234, 1'b0);
		add_row(mem_access_pkg::fetch_node,        20'h12345, 9'h011, 2'd1, 32'h0,         1'b0);
		add_row(mem_access_pkg::get_var,           20'h0ABCD, 9'h000, 2'd0, 32'h0,         1'b0);
		add_row(mem_access_pkg::fetch_simple_node, 20'h0ABCD, 9'h005, 2'd2, 32'h0,         1'b0);
		add_row(mem_access_pkg::get_var,           20'h777F0, 9'h000, 2'd1, 32'h0,         1'b1);
		add_row(mem_access_pkg::fetch_node,        20'h777F0, 9'h100, 2'd3, 32'h0,         1'b0);
		add_row(mem_access_pkg::get_var,           20'h777F0, 9'h000, 2'd2, 32'h0,         1'b1);
		add_row(mem_access_pkg::fetch_node,        20'hF2345, 9'h011, 2'd0, 32'h0,         1'b1);
		add_row(mem_access_pkg::fetch_node,        20'h12345, 9'h022, 2'd1, 32'h0,         1'b1);
		add_row(mem_access_pkg::write_node_next,   20'h0ABCD, 9'h005, 2'd0, 32'h0F0F_A5A5, 1'b0);
		add_row(mem_access_pkg::fetch_node,        20'h0ABCD, 9'h005, 2'd3, 32'h0,         1'b0);
		add_row(mem_access_pkg::fetch_simple_node, 20'h0ABCD, 9'h005, 2'd0, 32'h0,         1'b0);
		add_row(mem_access_pkg::fetch_node,        20'h0ABCD, 9'h000, 2'd1, 32'h0,         1'b0);
		add_row(mem_access_pkg::get_var,           20'h0ABCD, 9'h000, 2'd2, 32'h0,         1'b0);
		add_row(mem_access_pkg::fetch_simple_node, 20'h777F0, 9'h1FF, 2'd3, 32'h0,         1'b0);
		add_row(mem_access_pkg::fetch_node,        20'h777F0, 9'h0AA, 2'd0, 32'h0,         1'b0);
		add_row(mem_access_pkg::fetch_node,        20'h12345, 9'h033, 2'd1, 32'h0,         1'b0);
		add_row(mem_access_pkg::get_var,           20'h12345, 9'h000, 2'd2, 32'h0,         1'b0);
		add_row(mem_access_pkg::fetch_simple_node, 20'h12345, 9'h044, 2'd3, 32'h0,         1'b0);
		add_row(mem_access_pkg::fetch_node,        20'h0ABCD, 9'h155, 2'd0, 32'h0,         1'b0);
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_value(irq, 1'b0, "irq after reset");
		check_value(result_valid, 1'b0, "result_valid after reset");
		check_value({mem_read, mem_write}, 2'b00, "memory command after reset");
		check_value(cfg_readdatavalid, 1'b0, "cfg_readdatavalid after reset");
		check_value(req_ready, 1'b1, "req_ready after reset");
		for (int i = 0; i < row_type.size(); i++)
		begin
			if (i == clear_var_row)
				write_entry(row_page[i], entry_for(row_page[i]) & ~32'h1);
			reads_before = read_count;
			@(posedge clk);
			#1;
			req_type = row_type[i];
			req_page = row_page[i];
			req_node = row_node[i];
			req_channel = row_channel[i];
			req_data = row_data[i];
			req_valid = 1'b1;
			cur_page = row_page[i];
			cur_is_var = row_type[i] == mem_access_pkg::get_var;
			if (row_type[i] == mem_access_pkg::write_node_next)
			begin
				base = node_base(row_page[i], row_node[i]);
				ref_addr.push_back(base);
				ref_data.push_back(req_data[15:0]);
				ref_addr.push_back(base + 1);
				ref_data.push_back(req_data[31:16]);
			end
			else
			begin
				expected_data.push_back(expected_result(row_type[i], row_page[i], row_node[i]));
				expected_channel.push_back(row_channel[i]);
			end
			@(negedge clk);
			while (!req_ready)
				@(negedge clk);
			@(posedge clk);
			#1;
			req_valid = 1'b0;
			irq_seen = 1'b0;
			do
			begin
				@(negedge clk);
				if (irq)
					irq_seen = 1'b1;
			end
			while (!req_ready); // Lookup is idle again once the request is issued
			check_value(irq_seen, row_miss[i], "miss interrupt");
			check_bus(i, reads_before);
		end
		while (expected_data.size() != 0)
			@(negedge clk);
		cfg_read_word(mem_access_pkg::cfg_select_page, entry);
		check_value(entry, last_entry, "selected entry read");
		if (error_count == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("Done: errors found");
			$fatal(1, "Checks failed");
		end
	end
endmodule

`default_nettype wire

// File: files.f
rtl/mem_access_pkg.sv
rtl/page_table.sv
rtl/host_config.sv
rtl/page_lookup.sv
rtl/memory_issue.sv
rtl/response_collect.sv
rtl/mem_access_top.sv
verification/node_memory_model.sv
verification/tb_mem_access.sv
